/* logic/icache_pkg.sv */
package icache_pkg;

  // address and memory beat widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // 8 KB direct mapped, 128 lines of 64 bytes
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 7;
  localparam int TAG_W    = 19;
  localparam int LINES    = 128;

  // words per line, one refill beat per word
  localparam int WORDS_PER_LINE = 16;

  // burst length minus one, as carried in the len field
  localparam logic [7:0] REFILL_LEN = 8'd15;

  // fetches from here upward go straight to memory
  localparam logic [ADDR_W-1:0] UNCACHED_BASE = 32'hA000_0000;

  // fetch address split into cache fields
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } fetch_addr_t;

  // read request content, valid travels beside it
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } mem_req_t;

  // read data plus per-beat ready strobe
  typedef struct packed {
    logic [WORD_W-1:0] rdata;
    logic              ready;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED,
    RESPOND
  } ctrl_state_e;

endpackage

/* logic/icache_ctrl.sv */
module icache_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           fetch_valid_i,
  input  icache_pkg::fetch_addr_t        fetch_addr_i,
  input  logic                           hit_i,
  input  logic                           uncached_done_i,
  input  logic                           refill_done_i,
  output icache_pkg::fetch_addr_t        cur_addr_o,
  output logic [icache_pkg::INDEX_W-1:0] rd_index_o,
  output logic                           refill_start_o,
  output logic                           uncached_start_o,
  output logic                           respond_uncached_o,
  output logic                           inst_valid_o
);

  icache_pkg::ctrl_state_e state_q;
  icache_pkg::ctrl_state_e state_d;
  icache_pkg::fetch_addr_t addr_q;
  logic is_uncached;
  logic in_lookup;

  // region check on the accepted address
  assign is_uncached = addr_q >= icache_pkg::UNCACHED_BASE;
  assign in_lookup   = state_q == icache_pkg::LOOKUP;

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::IDLE: begin
        if (fetch_valid_i) begin
          state_d = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        // uncached goes to memory even if the tags happen to match
        if (is_uncached) begin
          state_d = icache_pkg::UNCACHED;
        end else if (hit_i) begin
          state_d = icache_pkg::IDLE;
        end else begin
          state_d = icache_pkg::REFILL;
        end
      end
      icache_pkg::REFILL: begin
        // back to idle, the cpu still holds the address so it is accepted again
        if (refill_done_i) begin
          state_d = icache_pkg::IDLE;
        end
      end
      icache_pkg::UNCACHED: begin
        if (uncached_done_i) begin
          state_d = icache_pkg::RESPOND;
        end
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= icache_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // capture on accept
  always_ff @(posedge clk) begin
    if (state_q == icache_pkg::IDLE && fetch_valid_i) begin
      addr_q <= fetch_addr_i;
    end
  end

  // raw index in idle so the data is ready in lookup
  assign rd_index_o = (state_q == icache_pkg::IDLE) ? fetch_addr_i.index : addr_q.index;
  assign cur_addr_o = addr_q;

  // one-cycle start pulses, only from lookup
  assign refill_start_o     = in_lookup && !is_uncached && !hit_i;
  assign uncached_start_o   = in_lookup && is_uncached;
  assign respond_uncached_o = state_q == icache_pkg::RESPOND;
  assign inst_valid_o       = (in_lookup && !is_uncached && hit_i) || respond_uncached_o;

endmodule

/* logic/icache_tag_array.sv */
module icache_tag_array (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [icache_pkg::INDEX_W-1:0] index_i,
  input  logic [icache_pkg::TAG_W-1:0]   tag_i,
  input  logic                           write_i,
  output logic                           hit_o
);

  // one valid bit per line
  logic [icache_pkg::LINES-1:0] valid_q;
  logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::LINES];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  // compare against the registered lookup address
  assign hit_o = valid_q[index_i] && (tag_mem[index_i] == tag_i);

endmodule

/* logic/icache_data_array.sv */
module icache_data_array (
  input  logic                                          clk,
  input  logic [icache_pkg::INDEX_W-1:0]                rd_index_i,
  input  logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] rd_word_i,
  output logic [2*icache_pkg::WORD_W-1:0]               rd_pair_o,
  input  logic                                          wr_en_i,
  input  logic [icache_pkg::INDEX_W-1:0]                wr_index_i,
  input  logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] wr_word_i,
  input  logic [icache_pkg::WORD_W-1:0]                 wr_data_i
);

  logic [icache_pkg::WORD_W-1:0] mem_q [icache_pkg::LINES][icache_pkg::WORDS_PER_LINE];
  logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] rd_next_word;

  // wraps inside the line, the line's last word pairs with its first
  assign rd_next_word = rd_word_i + 1'b1;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_index_i][wr_word_i] <= wr_data_i;
    end
  end

  // one cycle read latency
  // word w low, word w+1 high
  always_ff @(posedge clk) begin
    rd_pair_o <= {mem_q[rd_index_i][rd_next_word], mem_q[rd_index_i][rd_word_i]};
  end

endmodule

/* logic/line_refill.sv */
module line_refill (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          start_i,
  input  logic [icache_pkg::ADDR_W-1:0]                 line_addr_i,
  output icache_pkg::mem_req_t                          req_o,
  output logic                                          req_valid_o,
  input  icache_pkg::mem_rsp_t                          rsp_i,
  input  logic                                          grant_i,
  output logic                                          wr_en_o,
  output logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] wr_word_o,
  output logic [icache_pkg::WORD_W-1:0]                 wr_data_o,
  output logic                                          done_o
);

  logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-1:0] line_q;
  logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] beat_cnt_q;
  logic beat;
  logic last_beat;

  // ready only counts while we own the port
  assign beat      = req_valid_o && grant_i && rsp_i.ready;
  // counter is all ones on the final word of the line
  assign last_beat = beat && (&beat_cnt_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_o <= 1'b0;
      beat_cnt_q  <= '0;
      done_o      <= 1'b0;
    end else begin
      done_o <= last_beat;
      if (start_i) begin
        req_valid_o <= 1'b1;
        beat_cnt_q  <= '0;
      end else if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        // drop valid right after the beat numbered len
        if (last_beat) begin
          req_valid_o <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      line_q <= line_addr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];
    end
  end

  // line aligned burst, content fixed for the whole request
  assign req_o.addr = {line_q, {icache_pkg::OFFSET_W{1'b0}}};
  assign req_o.len  = icache_pkg::REFILL_LEN;

  // beat k lands in word k
  assign wr_en_o   = beat;
  assign wr_word_o = beat_cnt_q;
  assign wr_data_o = rsp_i.rdata;

endmodule

/* logic/uncached_reader.sv */
module uncached_reader (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start_i,
  input  logic [icache_pkg::ADDR_W-1:0] addr_i,
  output icache_pkg::mem_req_t          req_o,
  output logic                          req_valid_o,
  input  icache_pkg::mem_rsp_t          rsp_i,
  input  logic                          grant_i,
  output logic [icache_pkg::WORD_W-1:0] word_o,
  output logic                          done_o
);

  logic [icache_pkg::ADDR_W-3:0] word_addr_q;
  logic beat;

  assign beat = req_valid_o && grant_i && rsp_i.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      done_o <= beat;
      if (start_i) begin
        req_valid_o <= 1'b1;
      end else if (beat) begin
        // single beat, so the first one is also the last
        req_valid_o <= 1'b0;
      end
    end
  end

  // word address and returned data, held until the next start
  always_ff @(posedge clk) begin
    if (start_i) begin
      word_addr_q <= addr_i[icache_pkg::ADDR_W-1:2];
    end
    if (beat) begin
      word_o <= rsp_i.rdata;
    end
  end

  assign req_o.addr = {word_addr_q, 2'b00};
  assign req_o.len  = '0;

endmodule

/* logic/mem_read_arbiter.sv */
module mem_read_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  icache_pkg::mem_req_t refill_req_i,
  input  logic                 refill_valid_i,
  input  icache_pkg::mem_req_t unc_req_i,
  input  logic                 unc_valid_i,
  output icache_pkg::mem_req_t mem_req_o,
  output logic                 mem_req_valid_o,
  input  icache_pkg::mem_rsp_t mem_rsp_i,
  output logic                 refill_grant_o,
  output logic                 unc_grant_o
);

  logic lock_q;
  // 1 when the refill engine owns the locked burst
  logic owner_refill_q;
  logic [7:0] beat_cnt_q;
  logic pick_refill;
  logic beat;
  logic last_beat;

  // refill wins unless a burst is already in flight
  assign pick_refill = lock_q ? owner_refill_q : refill_valid_i;

  assign refill_grant_o  = pick_refill && refill_valid_i;
  assign unc_grant_o     = !pick_refill && unc_valid_i;
  assign mem_req_valid_o = refill_grant_o || unc_grant_o;
  assign mem_req_o       = pick_refill ? refill_req_i : unc_req_i;

  // track beats so the lock ends with the beat numbered len
  assign beat      = mem_req_valid_o && mem_rsp_i.ready;
  assign last_beat = beat && (beat_cnt_q == mem_req_o.len);

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_q         <= 1'b0;
      owner_refill_q <= 1'b0;
      beat_cnt_q     <= '0;
    end else if (last_beat) begin
      lock_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else if (mem_req_valid_o) begin
      lock_q         <= 1'b1;
      owner_refill_q <= pick_refill;
      if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

/* logic/inst_align.sv */
module inst_align (
  input  logic [2*icache_pkg::WORD_W-1:0] pair_i,
  input  logic                            half_sel_i,
  input  logic [icache_pkg::WORD_W-1:0]   uncached_word_i,
  input  logic                            respond_uncached_i,
  output logic [31:0]                     inst_o
);

  logic [2*icache_pkg::WORD_W-1:0] window;
  logic [15:0] cur_half;
  logic [15:0] next_half;

  // uncached word has nothing above it, upper half reads as zero
  assign window = respond_uncached_i ? {{icache_pkg::WORD_W{1'b0}}, uncached_word_i} : pair_i;

  // halfword at the fetch offset and the one after it
  assign cur_half  = half_sel_i ? window[31:16] : window[15:0];
  assign next_half = half_sel_i ? window[47:32] : window[31:16];

  // low bits 11 mark a 32-bit instruction
  // anything else is compressed, zero extended
  assign inst_o = (cur_half[1:0] == 2'b11) ? {next_half, cur_half} : {16'h0000, cur_half};

endmodule

/* logic/icache_top.sv */
module icache_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_valid_i,
  input  icache_pkg::fetch_addr_t fetch_addr_i,
  output logic [31:0]             inst_o,
  output logic                    inst_valid_o,
  output icache_pkg::mem_req_t    mem_req_o,
  output logic                    mem_req_valid_o,
  input  icache_pkg::mem_rsp_t    mem_rsp_i
);

  icache_pkg::fetch_addr_t cur_addr;
  logic [icache_pkg::INDEX_W-1:0] rd_index;
  logic [2*icache_pkg::WORD_W-1:0] rd_pair;
  logic hit;
  logic refill_start;
  logic refill_done;
  logic uncached_start;
  logic uncached_done;
  logic respond_uncached;
  logic [icache_pkg::WORD_W-1:0] uncached_word;
  // refill write port into the data array
  logic wr_en;
  logic [$clog2(icache_pkg::WORDS_PER_LINE)-1:0] wr_word;
  logic [icache_pkg::WORD_W-1:0] wr_data;
  // requester side of the memory arbiter
  icache_pkg::mem_req_t refill_req;
  icache_pkg::mem_req_t unc_req;
  logic refill_valid;
  logic unc_valid;
  logic refill_grant;
  logic unc_grant;

  icache_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_addr_i       (fetch_addr_i),
    .hit_i              (hit),
    .uncached_done_i    (uncached_done),
    .refill_done_i      (refill_done),
    .cur_addr_o         (cur_addr),
    .rd_index_o         (rd_index),
    .refill_start_o     (refill_start),
    .uncached_start_o   (uncached_start),
    .respond_uncached_o (respond_uncached),
    .inst_valid_o       (inst_valid_o)
  );

  // tag written from the held miss address when the refill ends
  icache_tag_array u_tag_array (
    .clk     (clk),
    .rst     (rst),
    .index_i (cur_addr.index),
    .tag_i   (cur_addr.tag),
    .write_i (refill_done),
    .hit_o   (hit)
  );

  // word select comes straight from the cpu, only used in the accepting cycle
  icache_data_array u_data_array (
    .clk        (clk),
    .rd_index_i (rd_index),
    .rd_word_i  (fetch_addr_i.offset[icache_pkg::OFFSET_W-1:2]),
    .rd_pair_o  (rd_pair),
    .wr_en_i    (wr_en),
    .wr_index_i (cur_addr.index),
    .wr_word_i  (wr_word),
    .wr_data_i  (wr_data)
  );

  // both engines see the raw response, the grant gates it
  line_refill u_line_refill (
    .clk         (clk),
    .rst         (rst),
    .start_i     (refill_start),
    .line_addr_i (cur_addr),
    .req_o       (refill_req),
    .req_valid_o (refill_valid),
    .rsp_i       (mem_rsp_i),
    .grant_i     (refill_grant),
    .wr_en_o     (wr_en),
    .wr_word_o   (wr_word),
    .wr_data_o   (wr_data),
    .done_o      (refill_done)
  );

  uncached_reader u_uncached_reader (
    .clk         (clk),
    .rst         (rst),
    .start_i     (uncached_start),
    .addr_i      (cur_addr),
    .req_o       (unc_req),
    .req_valid_o (unc_valid),
    .rsp_i       (mem_rsp_i),
    .grant_i     (unc_grant),
    .word_o      (uncached_word),
    .done_o      (uncached_done)
  );

  mem_read_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .refill_req_i    (refill_req),
    .refill_valid_i  (refill_valid),
    .unc_req_i       (unc_req),
    .unc_valid_i     (unc_valid),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_rsp_i       (mem_rsp_i),
    .refill_grant_o  (refill_grant),
    .unc_grant_o     (unc_grant)
  );

  inst_align u_inst_align (
    .pair_i             (rd_pair),
    .half_sel_i         (cur_addr.offset[1]),
    .uncached_word_i    (uncached_word),
    .respond_uncached_i (respond_uncached),
    .inst_o             (inst_o)
  );

endmodule

/* verification/icache_assertions.sv */
module icache_assertions (
  input logic                    clk,
  input logic                    rst,
  input logic                    fetch_valid_i,
  input icache_pkg::fetch_addr_t fetch_addr_i,
  input logic [31:0]             inst_i,
  input logic                    inst_valid_i,
  input icache_pkg::mem_req_t    mem_req_i,
  input logic                    mem_req_valid_i,
  input icache_pkg::mem_rsp_t    mem_rsp_i,
  input logic [31:0]             exp_inst_i,
  input logic                    exp_hit_i
);

  logic fetch_seen_q;
  // any request seen while the current fetch is held
  logic req_seen_q;
  logic [7:0] beats_q;
  logic beat;
  logic last_beat;
  logic uncached;
  icache_pkg::mem_req_t exp_req;
  // one flag per check
  bit quiet_err = 1'b0;
  bit req_err = 1'b0;
  bit hold_err = 1'b0;
  bit release_err = 1'b0;
  bit hit_err = 1'b0;
  bit mem_err = 1'b0;
  bit inst_err = 1'b0;
  bit pulse_err = 1'b0;
  logic fail_seen;

  assign beat      = mem_req_valid_i && mem_rsp_i.ready;
  assign last_beat = beat && (beats_q == mem_req_i.len);
  assign uncached  = fetch_addr_i >= icache_pkg::UNCACHED_BASE;

  // cached miss reads the whole line in 16 beats, uncached reads one word
  assign exp_req.addr = uncached ? {fetch_addr_i[31:2], 2'b00}
                                 : {fetch_addr_i.tag, fetch_addr_i.index, 6'd0};
  assign exp_req.len  = uncached ? 8'd0 : 8'd15;

  assign fail_seen = quiet_err | req_err | hold_err | release_err |
                     hit_err | mem_err | inst_err | pulse_err;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_seen_q <= 1'b0;
      req_seen_q   <= 1'b0;
      beats_q      <= '0;
    end else begin
      if (fetch_valid_i) begin
        fetch_seen_q <= 1'b1;
      end
      // cleared in the gap between two fetches
      if (!fetch_valid_i) begin
        req_seen_q <= 1'b0;
      end else if (mem_req_valid_i) begin
        req_seen_q <= 1'b1;
      end
      if (!mem_req_valid_i || last_beat) begin
        beats_q <= '0;
      end else if (beat) begin
        beats_q <= beats_q + 8'd1;
      end
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !fetch_seen_q |-> !mem_req_valid_i && !inst_valid_i)
    else begin
      $error("memory request or instruction seen before the first fetch");
      quiet_err = 1'b1;
    end

  a_req_content: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_i |-> mem_req_i == exp_req)
    else begin
      $error("FAILED mem_req_o 0x%h expected 0x%h", $sampled(mem_req_i), $sampled(exp_req));
      req_err = 1'b1;
    end

  // valid and content held until the beat numbered len
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_i && !last_beat |=> mem_req_valid_i && $stable(mem_req_i))
    else begin
      $error("memory request dropped or changed before its last beat");
      hold_err = 1'b1;
    end

  a_req_release: assert property (@(posedge clk) disable iff (rst)
    last_beat |=> !mem_req_valid_i)
    else begin
      $error("memory request still valid after its last beat");
      release_err = 1'b1;
    end

  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(fetch_valid_i) && exp_hit_i |=> inst_valid_i)
    else begin
      $error("hit did not respond one cycle after the fetch was accepted");
      hit_err = 1'b1;
    end

  // hits stay off the bus, misses and uncached reads use it
  a_mem_use: assert property (@(posedge clk) disable iff (rst)
    inst_valid_i |-> req_seen_q != exp_hit_i)
    else begin
      $error("memory request presence does not match the hit or miss of this fetch");
      mem_err = 1'b1;
    end

  a_inst_value: assert property (@(posedge clk) disable iff (rst)
    inst_valid_i |-> inst_i == exp_inst_i)
    else begin
      $error("FAILED inst_o 0x%h expected 0x%h", $sampled(inst_i), $sampled(exp_inst_i));
      inst_err = 1'b1;
    end

  a_single_pulse: assert property (@(posedge clk) disable iff (rst)
    inst_valid_i |=> !inst_valid_i)
    else begin
      $error("inst_valid_o high for two cycles in a row");
      pulse_err = 1'b1;
    end

endmodule

/* verification/tb_icache.sv */
module tb_icache;

  logic clk = 1'b0;
  logic rst;
  logic fetch_valid;
  icache_pkg::fetch_addr_t fetch_addr;
  logic [31:0] inst;
  logic inst_valid;
  icache_pkg::mem_req_t mem_req;
  logic mem_req_valid;
  icache_pkg::mem_rsp_t mem_rsp;
  // expected response of the fetch in flight
  logic [31:0] exp_inst;
  logic exp_hit;
  // shadow of which lines the cache should hold
  logic line_valid [icache_pkg::LINES];
  logic [icache_pkg::TAG_W-1:0] line_tag [icache_pkg::LINES];

  always #5 clk = ~clk;

  icache_top u_dut (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid),
    .fetch_addr_i    (fetch_addr),
    .inst_o          (inst),
    .inst_valid_o    (inst_valid),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_rsp_i       (mem_rsp)
  );

  bind icache_top icache_assertions u_assertions (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .inst_i          (inst_o),
    .inst_valid_i    (inst_valid_o),
    .mem_req_i       (mem_req_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_rsp_i       (mem_rsp_i),
    .exp_inst_i      (tb_icache.exp_inst),
    .exp_hit_i       (tb_icache.exp_hit)
  );

  // scrambled word per address, low halfword always opens a 32-bit instruction
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    w = (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
    w[1:0] = 2'b11;
    return w;
  endfunction

  function automatic logic [15:0] halfword_at(input logic [31:0] addr);
    logic [31:0] w;
    w = mem_word({addr[31:2], 2'b00});
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  // low bits 11 pull in the next halfword, else zero extended
  function automatic logic [31:0] expected_inst(input logic [31:0] addr);
    logic [15:0] h0;
    logic [15:0] h1;
    h0 = halfword_at(addr);
    h1 = halfword_at(addr + 32'd2);
    return (h0[1:0] == 2'b11) ? {h1, h0} : {16'h0000, h0};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  // memory side, random ready, beat k from addr + 4k
  task automatic run_memory();
    logic [31:0] beat_idx;
    logic beat_taken;
    logic beat_last;
    beat_idx = '0;
    beat_taken = 1'b0;
    beat_last = 1'b0;
    mem_rsp = '0;
    forever begin
      @(posedge clk);
      #1;
      if (beat_taken) begin
        beat_idx = beat_last ? 32'd0 : beat_idx + 32'd1;
      end
      mem_rsp.ready = ($urandom % 32'd4) != 32'd0;
      mem_rsp.rdata = mem_word(mem_req.addr + (beat_idx << 2));
      // decided now, the edge at the end of this cycle takes it
      beat_taken = !rst && mem_req_valid && mem_rsp.ready;
      beat_last = beat_taken && (beat_idx == {24'd0, mem_req.len});
    end
  endtask

  task automatic fetch(input logic [31:0] addr);
    int unsigned waited;
    logic got;
    logic cached;
    logic [icache_pkg::INDEX_W-1:0] idx;
    logic [icache_pkg::TAG_W-1:0] tag;
    idx = addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    tag = addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    cached = addr < icache_pkg::UNCACHED_BASE;
    @(posedge clk);
    #1;
    exp_hit = cached && line_valid[idx] && (line_tag[idx] == tag);
    exp_inst = expected_inst(addr);
    fetch_addr = addr;
    fetch_valid = 1'b1;
    waited = 0;
    got = 1'b0;
    while (!got && waited < 32'd200) begin
      @(posedge clk);
      #1;
      got = inst_valid;
      waited++;
    end
    if (!got) begin
      abort_run($sformatf("no instruction within 200 cycles for fetch at %h", addr));
    end else begin
      // cpu lets go one cycle after the response
      @(posedge clk);
      #1;
      fetch_valid = 1'b0;
      if (cached) begin
        line_valid[idx] = 1'b1;
        line_tag[idx] = tag;
      end
    end
  endtask

  // picks up any bound assertion failure
  always @(posedge clk) begin
    #2;
    if (u_dut.u_assertions.fail_seen) begin
      abort_run("a bound assertion failed");
    end
  end

  initial begin
    logic [31:0] off;
    logic [31:0] base;
    void'($urandom(302));
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    exp_inst = '0;
    exp_hit = 1'b0;
    for (int i = 0; i < icache_pkg::LINES; i++) begin
      line_valid[i] = 1'b0;
      line_tag[i] = '0;
    end
    fork
      run_memory();
    join_none
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // idle stretch, bus and response stay quiet
    repeat (4) @(posedge clk);
    // cold line then hits in it
    fetch(32'h0000_1004);
    fetch(32'h0000_1006);
    fetch(32'h0000_103C);
    for (int n = 0; n < 8; n++) begin
      off = ($urandom % 32'd31) * 32'd2;
      fetch(32'h0000_1000 + off);
    end
    fetch(32'h0002_0A42);
    fetch(32'h0002_0A40);
    // same index, other tag
    fetch(32'h0001_1010);
    fetch(32'h0000_1012);
    // top line just under the uncached region
    fetch(32'h9FFF_FFF8);
    // uncached, repeats go to memory again
    fetch(32'hA000_0000);
    fetch(32'hA000_0100);
    fetch(32'hA000_0100);
    fetch(32'h9FFF_FFF8);
    // random mix over four lines
    for (int n = 0; n < 16; n++) begin
      base = 32'h0004_0000 + (($urandom % 32'd4) << 6);
      off = ($urandom % 32'd31) * 32'd2;
      fetch(base + off);
    end
    repeat (3) @(posedge clk);
    #2;
    if (u_dut.u_assertions.fail_seen) begin
      abort_run("a bound assertion failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

/* vlog.f */
logic/icache_pkg.sv
logic/icache_ctrl.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/line_refill.sv
logic/uncached_reader.sv
logic/mem_read_arbiter.sv
logic/inst_align.sv
logic/icache_top.sv
verification/icache_assertions.sv
verification/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_icache -o sim_icache

# the testbench prints its own verdict, keep running so the log can be searched
./obj_dir/sim_icache +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
